// ==== logic/ingress_pkg.sv ====
// Sizes are fixed for two 8-bit and two 32-bit ports merged onto one 64-bit bus
// Ports 0 and 1 are the 8-bit ports, ports 2 and 3 the 32-bit ports
package ingress_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int NUM_8B_PORTS  = 2;
    localparam int NUM_32B_PORTS = 2;
    localparam int NUM_PORTS     = NUM_8B_PORTS + NUM_32B_PORTS;

    localparam int BUS_BYTES = 8;
    localparam int MTU_BYTES = 64;
    localparam int MTU_WORDS = (MTU_BYTES + BUS_BYTES - 1) / BUS_BYTES;

    // Two MTUs per port so a full packet can wait while the next one arrives
    localparam int BUF_DEPTH = 2 ** $clog2(2 * MTU_WORDS);

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [BUS_BYTES*8-1:0]       bus_data_t;
    typedef logic [BUS_BYTES-1:0]         bus_keep_t;
    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;
    // One extra bit above the address tells full from empty
    typedef logic [$clog2(BUF_DEPTH):0]   buf_ptr_t;
    typedef logic [15:0]                  cnt_t;
    typedef logic [31:0]                  bus_pkt_cnt_t;

    //////////////////////////////
    // Beat structs
    //////////////////////////////

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } in_8b_beat_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [3:0]  keep;
        logic        last;
    } in_32b_beat_t;

    typedef struct packed {
        bus_data_t data;
        bus_keep_t keep;
        logic      last;
    } word_t;

    typedef struct packed {
        bus_data_t data;
        bus_keep_t keep;
        logic      last;
        port_idx_t port;
    } bus_beat_t;

    typedef struct packed {
        cnt_t accepted;
        cnt_t dropped;
    } port_cnts_t;

    typedef enum logic {
        SCHED_IDLE,
        SCHED_SEND
    } sched_state_t;

endpackage

// ==== logic/ingress_port_buffer.sv ====
// Releases only complete packets; a packet that meets a full buffer is dropped whole
// Writes are never stalled, so rd_en must only come while pkt_ready is high
module ingress_port_buffer (
    input  logic                  AXIS_ARRAY,
    input  logic                  arst_n,
    input  ingress_pkg::word_t    word,
    input  logic                  word_valid,
    input  logic                  rd_en,
    input  logic                  cnt_clear,
    output ingress_pkg::word_t    head,
    output logic                  pkt_ready,
    output ingress_pkg::cnt_t     dropped_cnt,
    output logic                  overflow
);

    import ingress_pkg::*;

    word_t mem [BUF_DEPTH];

    // Write side runs ahead of the commit point until the packet's last word
    buf_ptr_t wr_ptr;
    buf_ptr_t commit_ptr;
    buf_ptr_t rd_ptr;
    buf_ptr_t used;
    buf_ptr_t pkt_cnt;

    logic dropping;
    logic full;
    logic wr_en;
    logic commit;
    logic release_pkt;
    logic drop_end;

    assign used        = wr_ptr - rd_ptr;
    assign full        = (used == buf_ptr_t'(BUF_DEPTH));
    assign wr_en       = word_valid && !dropping && !full;
    assign commit      = wr_en && word.last;
    assign release_pkt = rd_en && head.last;
    assign drop_end    = word_valid && !wr_en && word.last;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge AXIS_ARRAY) begin
        if (wr_en) begin
            mem[wr_ptr[$clog2(BUF_DEPTH)-1:0]] <= word;
        end
    end

    assign head      = mem[rd_ptr[$clog2(BUF_DEPTH)-1:0]];
    assign pkt_ready = (pkt_cnt != '0);

    //////////////////////////////
    // Pointers
    //////////////////////////////

    always_ff @(posedge AXIS_ARRAY or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            pkt_cnt    <= '0;
            dropping   <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (word.last) begin
                    commit_ptr <= wr_ptr + 1'b1;
                end
            end else if (word_valid) begin
                // No room, so the partial packet is thrown away up to its last word
                wr_ptr   <= commit_ptr;
                dropping <= !word.last;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            pkt_cnt <= pkt_cnt + buf_ptr_t'(commit) - buf_ptr_t'(release_pkt);
        end
    end

    // A dropped packet is counted once its last word has gone by
    always_ff @(posedge AXIS_ARRAY or negedge arst_n) begin
        if (!arst_n) begin
            dropped_cnt <= '0;
            overflow    <= 1'b0;
        end else if (cnt_clear) begin
            dropped_cnt <= '0;
            overflow    <= 1'b0;
        end else if (drop_end) begin
            overflow <= 1'b1;
            if (!(&dropped_cnt)) begin
                dropped_cnt <= dropped_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Occupancy never exceeds the memory, including words not yet committed
    a_no_overfill: assert property (@(posedge AXIS_ARRAY) disable iff (!arst_n)
        used <= buf_ptr_t'(BUF_DEPTH))
        else $error("port buffer written past its depth");

    // The scheduler must only pop from a port that holds a complete packet
    a_rd_when_ready: assert property (@(posedge AXIS_ARRAY) disable iff (!arst_n)
        rd_en |-> pkt_ready)
        else $error("port buffer read without a complete packet");

endmodule

// ==== logic/ingress_scheduler.sv ====
// Grants one port at a time and sends its whole packet before searching again
// A granted packet is assumed complete in its buffer, so the grant never waits on data
module ingress_scheduler (
    input  logic                                AXIS_ARRAY,
    input  logic                                arst_n,
    input  ingress_pkg::word_t                  heads [ingress_pkg::NUM_PORTS],
    input  logic [ingress_pkg::NUM_PORTS-1:0]   pkt_ready,
    input  logic                                out_ready,
    output logic [ingress_pkg::NUM_PORTS-1:0]   rd_en,
    output ingress_pkg::bus_beat_t              bus,
    output logic                                out_valid
);

    import ingress_pkg::*;

    sched_state_t state;
    port_idx_t    grant;
    port_idx_t    last_grant;
    port_idx_t    next_port;
    logic         found;
    logic         xfer;

    //////////////////////////////
    // Round-robin search
    //////////////////////////////

    // Walk backwards so the port nearest after the last grant is the one kept
    always_comb begin
        int cand;
        found     = 1'b0;
        next_port = last_grant;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            cand = (int'(last_grant) + i) % NUM_PORTS;
            if (pkt_ready[cand]) begin
                found     = 1'b1;
                next_port = port_idx_t'(cand);
            end
        end
    end

    //////////////////////////////
    // Output bus
    //////////////////////////////

    assign out_valid = (state == SCHED_SEND);
    assign xfer      = out_valid && out_ready;

    assign bus = '{data: heads[grant].data,
                   keep: heads[grant].keep,
                   last: heads[grant].last,
                   port: grant};

    always_comb begin
        rd_en        = '0;
        rd_en[grant] = xfer;
    end

    always_ff @(posedge AXIS_ARRAY or negedge arst_n) begin
        if (!arst_n) begin
            state      <= SCHED_IDLE;
            grant      <= '0;
            // Port 0 comes first after reset
            last_grant <= port_idx_t'(NUM_PORTS - 1);
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (found) begin
                        grant <= next_port;
                        state <= SCHED_SEND;
                    end
                end
                SCHED_SEND: begin
                    if (xfer && bus.last) begin
                        last_grant <= grant;
                        state      <= SCHED_IDLE;
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // The buffer head must not move while the bus is stalled
    a_hold_on_stall: assert property (@(posedge AXIS_ARRAY) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(bus) && $stable(grant))
        else $error("bus beat changed while stalled");

    // The granted buffer keeps its complete packet until the last word has left
    a_grant_has_pkt: assert property (@(posedge AXIS_ARRAY) disable iff (!arst_n)
        out_valid |-> pkt_ready[grant])
        else $error("granted port has no complete packet");

endmodule

// ==== logic/ingress_top.sv ====
// Narrow inputs have no ready and are never stalled; only the output bus sees back-pressure
// Packets longer than the MTU are not supported
module ingress_top (
    input  logic                                AXIS_ARRAY,
    input  logic                                arst_n,
    input  ingress_pkg::in_8b_beat_t            in_8b [ingress_pkg::NUM_8B_PORTS],
    input  ingress_pkg::in_32b_beat_t           in_32b [ingress_pkg::NUM_32B_PORTS],
    input  logic [ingress_pkg::NUM_PORTS-1:0]   port_enable,
    input  logic [ingress_pkg::NUM_PORTS-1:0]   cnts_clear,
    input  logic                                out_ready,
    input  logic                                bus_pkt_cnt_clear,
    output ingress_pkg::bus_beat_t              bus,
    output logic                                out_valid,
    output ingress_pkg::port_cnts_t             port_cnts [ingress_pkg::NUM_PORTS],
    output logic [ingress_pkg::NUM_PORTS-1:0]   overflow,
    output ingress_pkg::bus_pkt_cnt_t           bus_pkt_cnt
);

    import ingress_pkg::*;

    word_t                words [NUM_PORTS];
    logic [NUM_PORTS-1:0] word_valid;
    word_t                heads [NUM_PORTS];
    logic [NUM_PORTS-1:0] pkt_ready;
    logic [NUM_PORTS-1:0] rd_en;
    cnt_t                 accepted_cnt [NUM_PORTS];
    cnt_t                 dropped_cnt [NUM_PORTS];
    logic                 xfer_last;

    //////////////////////////////
    // Width adapters
    //////////////////////////////

    for (genvar p = 0; p < NUM_8B_PORTS; p++) begin : g_adapt_8b
        ingress_width_adapter #(.IN_BYTES(1)) i_adapter (
            .AXIS_ARRAY   (AXIS_ARRAY),
            .arst_n       (arst_n),
            .in_valid     (in_8b[p].valid),
            .in_data      (in_8b[p].data),
            .in_keep      (1'b1),
            .in_last      (in_8b[p].last),
            .enable       (port_enable[p]),
            .cnt_clear    (cnts_clear[p]),
            .word         (words[p]),
            .word_valid   (word_valid[p]),
            .accepted_cnt (accepted_cnt[p])
        );
    end

    // The 32-bit ports follow the 8-bit ones in the port numbering
    for (genvar p = 0; p < NUM_32B_PORTS; p++) begin : g_adapt_32b
        ingress_width_adapter #(.IN_BYTES(4)) i_adapter (
            .AXIS_ARRAY   (AXIS_ARRAY),
            .arst_n       (arst_n),
            .in_valid     (in_32b[p].valid),
            .in_data      (in_32b[p].data),
            .in_keep      (in_32b[p].keep),
            .in_last      (in_32b[p].last),
            .enable       (port_enable[NUM_8B_PORTS+p]),
            .cnt_clear    (cnts_clear[NUM_8B_PORTS+p]),
            .word         (words[NUM_8B_PORTS+p]),
            .word_valid   (word_valid[NUM_8B_PORTS+p]),
            .accepted_cnt (accepted_cnt[NUM_8B_PORTS+p])
        );
    end

    //////////////////////////////
    // Buffers and scheduler
    //////////////////////////////

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_buf
        ingress_port_buffer i_buffer (
            .AXIS_ARRAY  (AXIS_ARRAY),
            .arst_n      (arst_n),
            .word        (words[p]),
            .word_valid  (word_valid[p]),
            .rd_en       (rd_en[p]),
            .cnt_clear   (cnts_clear[p]),
            .head        (heads[p]),
            .pkt_ready   (pkt_ready[p]),
            .dropped_cnt (dropped_cnt[p]),
            .overflow    (overflow[p])
        );

        assign port_cnts[p] = '{accepted: accepted_cnt[p], dropped: dropped_cnt[p]};
    end

    ingress_scheduler i_scheduler (
        .AXIS_ARRAY (AXIS_ARRAY),
        .arst_n     (arst_n),
        .heads      (heads),
        .pkt_ready  (pkt_ready),
        .out_ready  (out_ready),
        .rd_en      (rd_en),
        .bus        (bus),
        .out_valid  (out_valid)
    );

    // Output packet counter saturates, and clear takes priority over a count
    assign xfer_last = out_valid && out_ready && bus.last;

    always_ff @(posedge AXIS_ARRAY or negedge arst_n) begin
        if (!arst_n) begin
            bus_pkt_cnt <= '0;
        end else if (bus_pkt_cnt_clear) begin
            bus_pkt_cnt <= '0;
        end else if (xfer_last && !(&bus_pkt_cnt)) begin
            bus_pkt_cnt <= bus_pkt_cnt + 1'b1;
        end
    end

endmodule

// ==== logic/ingress_width_adapter.sv ====
// Input keep must be contiguous from byte 0 and may be partial only on the last beat
// IN_BYTES must divide the bus width (1, 2, 4 or 8), and the input is never stalled
module ingress_width_adapter #(
    parameter int IN_BYTES = 1
) (
    input  logic                      AXIS_ARRAY,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  logic [IN_BYTES*8-1:0]     in_data,
    input  logic [IN_BYTES-1:0]       in_keep,
    input  logic                      in_last,
    input  logic                      enable,
    input  logic                      cnt_clear,
    output ingress_pkg::word_t        word,
    output logic                      word_valid,
    output ingress_pkg::cnt_t         accepted_cnt
);

    import ingress_pkg::*;

    // Partial word being filled and its fill level in bytes
    bus_data_t                     part_data;
    bus_keep_t                     part_keep;
    logic [$clog2(BUS_BYTES):0]    fill;

    bus_data_t                     nxt_data;
    bus_keep_t                     nxt_keep;
    logic [$clog2(BUS_BYTES):0]    nxt_fill;

    logic mid_pkt;
    logic pkt_accept;
    logic pkt_start;
    logic take;
    logic word_done;

    //////////////////////////////
    // Packet gating
    //////////////////////////////

    // Enable only matters on the first beat of a packet
    assign pkt_start = in_valid && !mid_pkt;
    assign take      = in_valid && (mid_pkt ? pkt_accept : enable);

    //////////////////////////////
    // Byte packing
    //////////////////////////////

    always_comb begin
        int idx;
        nxt_data = part_data;
        nxt_keep = part_keep;
        nxt_fill = fill;
        for (int b = 0; b < IN_BYTES; b++) begin
            idx = int'(fill) + b;
            if (in_keep[b] && idx < BUS_BYTES) begin
                nxt_data[idx*8 +: 8] = in_data[b*8 +: 8];
                nxt_keep[idx]        = 1'b1;
                nxt_fill             = nxt_fill + 1'b1;
            end
        end
    end

    assign word_done = in_last || (int'(nxt_fill) == BUS_BYTES);

    always_ff @(posedge AXIS_ARRAY or negedge arst_n) begin
        if (!arst_n) begin
            mid_pkt    <= 1'b0;
            pkt_accept <= 1'b0;
            part_data  <= '0;
            part_keep  <= '0;
            fill       <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= take && word_done;
            if (in_valid) begin
                mid_pkt <= !in_last;
            end
            if (pkt_start) begin
                pkt_accept <= enable;
            end
            if (take) begin
                if (word_done) begin
                    part_data <= '0;
                    part_keep <= '0;
                    fill      <= '0;
                end else begin
                    part_data <= nxt_data;
                    part_keep <= nxt_keep;
                    fill      <= nxt_fill;
                end
            end
        end
    end

    always_ff @(posedge AXIS_ARRAY) begin
        if (take && word_done) begin
            word <= '{data: nxt_data, keep: nxt_keep, last: in_last};
        end
    end

    // Accepted packets are counted on their last beat, saturating
    always_ff @(posedge AXIS_ARRAY or negedge arst_n) begin
        if (!arst_n) begin
            accepted_cnt <= '0;
        end else if (cnt_clear) begin
            accepted_cnt <= '0;
        end else if (take && in_last && !(&accepted_cnt)) begin
            accepted_cnt <= accepted_cnt + 1'b1;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds with Verilator, runs into sim.log, then reads the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ingress_top \
    -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"

// ==== tb.f ====
logic/ingress_pkg.sv
logic/ingress_width_adapter.sv
logic/ingress_port_buffer.sv
logic/ingress_scheduler.sv
logic/ingress_top.sv
testbench/tb_clock_gen.sv
testbench/tb_ingress_top.sv

// ==== testbench/tb_clock_gen.sv ====
// Clock period is 8 time units, reset is held low for the first 8 rising edges
module tb_clock_gen (
    output logic AXIS_ARRAY,
    output logic arst_n
);

    initial begin
        AXIS_ARRAY = 1'b0;
        forever begin
            #4 AXIS_ARRAY = ~AXIS_ARRAY;
        end
    end

    // Release lands just after an edge so no flop sees it at the same time as the clock
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge AXIS_ARRAY);
        #1 arst_n = 1'b1;
    end

endmodule

// ==== testbench/tb_ingress_top.sv ====
// Inputs change 1 unit after the rising edge and outputs are sampled on the falling edge
// Expected packets are queued per port, so one port's output order is checked strictly
module tb_ingress_top;

    import ingress_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RAND_PKTS      = 10;

    typedef enum int {READY_HIGH, READY_RANDOM, READY_LOW} ready_mode_t;

    logic                 AXIS_ARRAY;
    logic                 arst_n;
    in_8b_beat_t          in_8b [NUM_8B_PORTS];
    in_32b_beat_t         in_32b [NUM_32B_PORTS];
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] cnts_clear;
    logic                 out_ready;
    logic                 bus_pkt_cnt_clear;
    bus_beat_t            bus;
    logic                 out_valid;
    port_cnts_t           port_cnts [NUM_PORTS];
    logic [NUM_PORTS-1:0] overflow;
    bus_pkt_cnt_t         bus_pkt_cnt;

    ready_mode_t ready_mode;
    int          errors;
    int          cycle_cnt;
    int          last_xfers;
    int          out_pkts [NUM_PORTS];
    int          acc_exp [NUM_PORTS];
    logic [7:0]  exp_bytes [NUM_PORTS][$];
    int          exp_len [NUM_PORTS][$];
    logic [7:0]  cur_bytes [$];
    port_idx_t   cur_port;

    tb_clock_gen i_clock_gen (.AXIS_ARRAY(AXIS_ARRAY), .arst_n(arst_n));

    ingress_top i_ingress_top (
        .AXIS_ARRAY        (AXIS_ARRAY),
        .arst_n            (arst_n),
        .in_8b             (in_8b),
        .in_32b            (in_32b),
        .port_enable       (port_enable),
        .cnts_clear        (cnts_clear),
        .out_ready         (out_ready),
        .bus_pkt_cnt_clear (bus_pkt_cnt_clear),
        .bus               (bus),
        .out_valid         (out_valid),
        .port_cnts         (port_cnts),
        .overflow          (overflow),
        .bus_pkt_cnt       (bus_pkt_cnt)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        assert (expected == actual) else begin
            errors++;
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic to_drive_point();
        @(posedge AXIS_ARRAY);
        #1;
    endtask

    task automatic send_packet(input int port, input int len, input bit lost);
        logic [7:0]  pkt [$];
        logic [31:0] data;
        logic [3:0]  keep;
        int          nbeats;
        for (int i = 0; i < len; i++) begin
            pkt.push_back(8'($urandom));
        end
        // The adapter looks at the enable only on the first beat
        if (port_enable[port]) begin
            acc_exp[port]++;
            if (!lost) begin
                exp_len[port].push_back(len);
                foreach (pkt[i]) begin
                    exp_bytes[port].push_back(pkt[i]);
                end
            end
        end
        if (port < NUM_8B_PORTS) begin
            for (int i = 0; i < len; i++) begin
                in_8b[port] = '{valid: 1'b1, data: pkt[i], last: (i == len - 1)};
                to_drive_point();
            end
            in_8b[port] = '0;
        end else begin
            nbeats = (len + 3) / 4;
            for (int b = 0; b < nbeats; b++) begin
                data = '0;
                keep = '0;
                for (int k = 0; k < 4; k++) begin
                    if (4 * b + k < len) begin
                        data[k*8 +: 8] = pkt[4*b+k];
                        keep[k]        = 1'b1;
                    end
                end
                in_32b[port-NUM_8B_PORTS] =
                    '{valid: 1'b1, data: data, keep: keep, last: (b == nbeats - 1)};
                to_drive_point();
            end
            in_32b[port-NUM_8B_PORTS] = '0;
        end
    endtask

    // Two MTU packets fill a buffer exactly, so a third one waits for the oldest to leave
    task automatic send_random(input int port);
        for (int n = 0; n < RAND_PKTS; n++) begin
            while (exp_len[port].size() > 1) begin
                to_drive_point();
            end
            send_packet(port, $urandom_range(MTU_BYTES, 1), 1'b0);
        end
    endtask

    task automatic wait_drain();
        int pending;
        do begin
            @(posedge AXIS_ARRAY);
            pending = 0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                pending += exp_len[p].size();
            end
        end while (pending != 0);
        @(negedge AXIS_ARRAY);
    endtask

    task automatic check_idle();
        repeat (2 * MTU_WORDS) begin
            @(negedge AXIS_ARRAY);
            assert (!out_valid) else report_error("bus carried a packet that was not expected");
        end
    endtask

    task automatic check_accepted();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("port_cnts[%0d].accepted", p), acc_exp[p],
                        port_cnts[p].accepted);
        end
    endtask

    task automatic report_and_finish();
        $display("Run ended after %0d cycles with %0d errors", cycle_cnt, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    //////////////////////////////
    // Bus monitor
    //////////////////////////////

    task automatic collect_beat();
        int         exp_n;
        logic [7:0] exp_b;
        if (cur_bytes.size() > 0) begin
            check_value("bus.port", cur_port, bus.port);
        end else begin
            cur_port = bus.port;
        end
        if (!bus.last) begin
            check_value("bus.keep", 8'hff, bus.keep);
        end else begin
            assert (bus.keep != '0 && (bus.keep & (bus.keep + 1'b1)) == '0)
                else report_error($sformatf("last beat keep 0x%0h is not packed", bus.keep));
        end
        for (int b = 0; b < BUS_BYTES; b++) begin
            if (bus.keep[b]) begin
                cur_bytes.push_back(bus.data[b*8 +: 8]);
            end
        end
        if (bus.last) begin
            last_xfers++;
            out_pkts[cur_port]++;
            assert (exp_len[cur_port].size() != 0)
                else report_error($sformatf("packet from port %0d with none pending", cur_port));
            if (exp_len[cur_port].size() != 0) begin
                exp_n = exp_len[cur_port].pop_front();
                check_value("packet length", exp_n, cur_bytes.size());
                for (int i = 0; i < exp_n; i++) begin
                    exp_b = exp_bytes[cur_port].pop_front();
                    if (i < cur_bytes.size()) begin
                        check_value($sformatf("bus.data byte %0d", i), exp_b, cur_bytes[i]);
                    end
                end
            end
            cur_bytes.delete();
        end
    endtask

    always @(negedge AXIS_ARRAY) begin
        if (arst_n && out_valid && out_ready) begin
            collect_beat();
        end
    end

    always @(posedge AXIS_ARRAY) begin
        #1;
        case (ready_mode)
            READY_RANDOM: out_ready = ($urandom_range(3, 0) != 0);
            READY_LOW:    out_ready = 1'b0;
            default:      out_ready = 1'b1;
        endcase
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge AXIS_ARRAY);
            cycle_cnt++;
        end
        report_error($sformatf("timeout, run did not finish in %0d cycles", TIMEOUT_CYCLES));
        report_and_finish();
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int base;
        void'($urandom(20));
        errors     = 0;
        last_xfers = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            out_pkts[p] = 0;
            acc_exp[p]  = 0;
        end
        in_8b             = '{default: '0};
        in_32b            = '{default: '0};
        port_enable       = '1;
        cnts_clear        = '0;
        bus_pkt_cnt_clear = 1'b0;
        out_ready         = 1'b0;
        ready_mode        = READY_HIGH;
        wait (arst_n === 1'b1);
        to_drive_point();

        // One packet per port with the bus always ready
        fork
            send_packet(0, 13, 1'b0);
            send_packet(1, 8, 1'b0);
            send_packet(2, 37, 1'b0);
            send_packet(3, MTU_BYTES, 1'b0);
        join
        wait_drain();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("packets out of port %0d", p), 1, out_pkts[p]);
        end
        check_value("bus_pkt_cnt", 4, bus_pkt_cnt);

        // Random lengths on all ports against a random ready
        ready_mode = READY_RANDOM;
        to_drive_point();
        fork
            send_random(0);
            send_random(1);
            send_random(2);
            send_random(3);
        join
        wait_drain();
        ready_mode = READY_HIGH;
        check_accepted();
        check_value("bus_pkt_cnt", last_xfers, bus_pkt_cnt);

        // Port 1 starts disabled and port 2 loses its enable in the middle of a packet
        to_drive_point();
        port_enable[1] = 1'b0;
        fork
            send_packet(1, 20, 1'b0);
            send_packet(2, 40, 1'b0);
            begin
                repeat (4) to_drive_point();
                port_enable[2] = 1'b0;
            end
        join
        send_packet(2, 12, 1'b0);
        port_enable = '1;
        wait_drain();
        check_idle();
        check_accepted();

        // Three MTU packets on port 2 while the bus is stalled, the third has no room
        ready_mode = READY_LOW;
        base       = out_pkts[2];
        to_drive_point();
        send_packet(2, MTU_BYTES, 1'b0);
        send_packet(2, MTU_BYTES, 1'b0);
        send_packet(2, MTU_BYTES, 1'b1);
        repeat (2) @(negedge AXIS_ARRAY);
        // Only port 2 may have overflowed
        check_value("overflow", 1 << 2, overflow);
        check_value("port_cnts[2].dropped", 1, port_cnts[2].dropped);
        check_accepted();
        ready_mode = READY_HIGH;
        wait_drain();
        check_idle();
        check_value("packets out of port 2", base + 2, out_pkts[2]);
        to_drive_point();
        cnts_clear[2] = 1'b1;
        to_drive_point();
        cnts_clear[2] = 1'b0;
        acc_exp[2]    = 0;
        @(negedge AXIS_ARRAY);
        check_value("port_cnts[2].accepted", 0, port_cnts[2].accepted);
        check_value("port_cnts[2].dropped", 0, port_cnts[2].dropped);
        check_value("overflow", 0, overflow);

        // Output packet counter and its clear
        check_value("bus_pkt_cnt", last_xfers, bus_pkt_cnt);
        to_drive_point();
        bus_pkt_cnt_clear = 1'b1;
        to_drive_point();
        bus_pkt_cnt_clear = 1'b0;
        @(negedge AXIS_ARRAY);
        check_value("bus_pkt_cnt", 0, bus_pkt_cnt);
        report_and_finish();
    end

endmodule
